// File: logic/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import odd_pipe_pkg::*;
(
    input  odd_opcode_t op,
    input  pc_t         rb_word,
    input  logic [0:15] i16,
    input  pc_t         pc,
    output logic        taken,
    output logic        flush,
    output pc_t         target,
    output pc_t         link_value
);

    pc_t offset;
    pc_t rel_target;
    pc_t dest;

    // word offset, sign extended
    assign offset     = {{14{i16[0]}}, i16, 2'b00};
    assign rel_target = pc + offset;

    always_comb
    begin
        taken = 1'b0;
        dest  = rel_target;
        case (op)
            BR:   taken = 1'b1;
            BRSL: taken = 1'b1;
            BRA:
            begin
                taken = 1'b1;
                dest  = offset;
            end
            BRZ:  taken = (rb_word == '0);
            BRNZ: taken = (rb_word != '0);
            default: taken = 1'b0;
        endcase
    end

    // younger work behind a taken branch is squashed
    assign flush = taken;

    assign target = taken ? dest : '0;

    // return address for BRSL
    assign link_value = pc + 32'd4;

endmodule

`default_nettype wire

// File: logic/forward_stages.sv
`timescale 1ns/1ps
`default_nettype none

module forward_stages
    import odd_pipe_pkg::*;
#(
    parameter int FWD_DEPTH = 7
)
(
    input  logic                             clock,
    input  logic                             reset,
    input  fwd_entry_t                       stage_one,
    output fwd_entry_t [0:FWD_DEPTH-1]       stages
);

    // stages two and up; stage one is the execute result itself
    fwd_entry_t [1:FWD_DEPTH-1] stage_q;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage_q <= '0;
        end
        else
        begin
            stage_q[1] <= stage_one;
            for (int k = 2; k < FWD_DEPTH; k++)
            begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    always_comb
    begin
        stages[0] = stage_one;
        for (int k = 1; k < FWD_DEPTH; k++)
        begin
            stages[k] = stage_q[k];
        end
    end

endmodule

`default_nettype wire

// File: logic/odd_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module odd_pipe
    import odd_pipe_pkg::*;
#(
    parameter int FWD_DEPTH = 7
)
(
    input  logic                       clock,
    input  logic                       reset,
    input  odd_instr_t                 instr,
    output fwd_entry_t [0:FWD_DEPTH-1] fwd_stages,
    output logic                       branch_taken,
    output logic                       flush,
    output pc_t                        target_pc
);

    odd_instr_t issued;
    quadword_t  perm_value;
    logic       taken;
    logic       br_flush;
    pc_t        target;
    pc_t        link_value;
    fwd_entry_t stage_one;

    odd_pipe_issue u_issue (
        .clock  (clock),
        .reset  (reset),
        .flush  (br_flush),
        .instr  (instr),
        .issued (issued)
    );

    permute_unit u_permute (
        .op     (issued.opcode),
        .ra     (issued.ra),
        .rb     (issued.rb),
        .i7     (issued.i7),
        .result (perm_value)
    );

    branch_unit u_branch (
        .op         (issued.opcode),
        .rb_word    (issued.rb[0:31]),
        .i16        (issued.i16),
        .pc         (issued.pc),
        .taken      (taken),
        .flush      (br_flush),
        .target     (target),
        .link_value (link_value)
    );

    // stage one entry, a NOP leaves it all zero
    always_comb
    begin
        stage_one = '0;
        if (issued.opcode inside {SHLQBI, SHLQBII, SHLQBY, SHLQBYI,
                                  ROTQBI, ROTQBII, ROTQBY, ROTQBYI})
        begin
            stage_one.unit_id      = UNIT_PERMUTE;
            stage_one.rt_value     = perm_value;
            stage_one.write_enable = 1'b1;
            stage_one.rt_address   = issued.rt_address;
            stage_one.latency      = LAT_PERMUTE;
        end
        else if (issued.opcode inside {BR, BRA, BRSL, BRZ, BRNZ})
        begin
            stage_one.unit_id    = UNIT_BRANCH;
            stage_one.rt_address = issued.rt_address;
            stage_one.latency    = LAT_BRANCH;
            // only BRSL writes back, link in the first word
            if (issued.opcode == BRSL)
            begin
                stage_one.write_enable = 1'b1;
                stage_one.rt_value     = {link_value, 96'd0};
            end
        end
    end

    forward_stages #(
        .FWD_DEPTH (FWD_DEPTH)
    ) u_stages (
        .clock     (clock),
        .reset     (reset),
        .stage_one (stage_one),
        .stages    (fwd_stages)
    );

    assign branch_taken = taken;
    assign flush        = br_flush;
    assign target_pc    = target;

endmodule

`default_nettype wire

// File: logic/odd_pipe_issue.sv
`timescale 1ns/1ps
`default_nettype none

module odd_pipe_issue
    import odd_pipe_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  odd_instr_t instr,
    output odd_instr_t issued
);

    odd_instr_t issue_q;

    // a taken branch at issue kills the instruction presented alongside it,
    // an all-zero word is a NOP with no fields set
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            issue_q <= '0;
        end
        else if (flush)
        begin
            issue_q <= '0;
        end
        else
        begin
            issue_q <= instr;
        end
    end

    assign issued = issue_q;

endmodule

`default_nettype wire

// File: logic/odd_pipe_pkg.sv
`default_nettype none

package odd_pipe_pkg;

    localparam int QUAD_BITS = 128;
    localparam int BYTE_BITS = 8;

    // bit 0 is the most significant bit throughout the pipe
    typedef logic [0:QUAD_BITS-1] quadword_t;
    typedef logic [0:31] pc_t;
    typedef logic [0:6] reg_addr_t;
    typedef logic [0:2] unit_id_t;
    typedef logic [0:3] latency_t;

    // NOP must stay at zero so a cleared issue register decodes as idle
    typedef enum logic [3:0] {
        NOP     = 4'd0,
        SHLQBI  = 4'd1,
        SHLQBII = 4'd2,
        SHLQBY  = 4'd3,
        SHLQBYI = 4'd4,
        ROTQBI  = 4'd5,
        ROTQBII = 4'd6,
        ROTQBY  = 4'd7,
        ROTQBYI = 4'd8,
        BR      = 4'd9,
        BRA     = 4'd10,
        BRSL    = 4'd11,
        BRZ     = 4'd12,
        BRNZ    = 4'd13
    } odd_opcode_t;

    localparam unit_id_t UNIT_PERMUTE = 3'd5;
    localparam unit_id_t UNIT_BRANCH  = 3'd7;

    localparam latency_t LAT_PERMUTE = 4'd4;
    localparam latency_t LAT_BRANCH  = 4'd1;

    typedef struct packed {
        odd_opcode_t opcode;
        quadword_t   ra;
        quadword_t   rb;
        reg_addr_t   rt_address;
        logic [0:6]  i7;
        logic [0:15] i16;
        pc_t         pc;
    } odd_instr_t;

    // layout seen by the register file and bypass network
    typedef struct packed {
        unit_id_t  unit_id;
        quadword_t rt_value;
        logic      write_enable;
        reg_addr_t rt_address;
        latency_t  latency;
    } fwd_entry_t;

endpackage

`default_nettype wire

// File: logic/permute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module permute_unit
    import odd_pipe_pkg::*;
(
    input  odd_opcode_t op,
    input  quadword_t   ra,
    input  quadword_t   rb,
    input  logic [0:6]  i7,
    output quadword_t   result
);

    logic                   is_permute;
    logic                   use_imm;
    logic                   by_bytes;
    logic                   rotate;
    logic [0:4]             raw_count;
    logic [7:0]             byte_count;
    logic [7:0]             shift_amt;
    logic [0:2*QUAD_BITS-1] wide;

    // operation class from the opcode
    always_comb
    begin
        is_permute = 1'b1;
        use_imm    = 1'b0;
        by_bytes   = 1'b0;
        rotate     = 1'b0;
        case (op)
            SHLQBI:  ;
            SHLQBII: use_imm = 1'b1;
            SHLQBY:  by_bytes = 1'b1;
            SHLQBYI:
            begin
                by_bytes = 1'b1;
                use_imm  = 1'b1;
            end
            ROTQBI:  rotate = 1'b1;
            ROTQBII:
            begin
                rotate  = 1'b1;
                use_imm = 1'b1;
            end
            ROTQBY:
            begin
                rotate   = 1'b1;
                by_bytes = 1'b1;
            end
            ROTQBYI:
            begin
                rotate   = 1'b1;
                by_bytes = 1'b1;
                use_imm  = 1'b1;
            end
            default: is_permute = 1'b0;
        endcase
    end

    // count comes from the first word of rb or from i7
    assign raw_count = use_imm ? i7[2:6] : rb[27:31];

    always_comb
    begin
        if (!by_bytes)
        begin
            byte_count = 8'd0;
            shift_amt  = {5'd0, raw_count[2:4]};
        end
        else
        begin
            // rotate wraps modulo 16 bytes, shift keeps all five bits
            byte_count = rotate ? {4'd0, raw_count[1:4]} : {3'd0, raw_count};
            shift_amt  = byte_count * 8'(BYTE_BITS);
        end
    end

    // lower half refills with ra for a rotate, zeros for a shift;
    // counts of 16 bytes or more push every ra bit out
    assign wide = {ra, (rotate ? ra : quadword_t'('0))} << shift_amt;

    assign result = is_permute ? wide[0:QUAD_BITS-1] : '0;

endmodule

`default_nettype wire

// File: odd_pipe.f
logic/odd_pipe_pkg.sv
logic/odd_pipe_issue.sv
logic/permute_unit.sv
logic/branch_unit.sv
logic/forward_stages.sv
logic/odd_pipe.sv
testbench/tb_clock_gen.sv
testbench/odd_pipe_assert.sv
testbench/odd_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the odd pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module odd_pipe_tb \
    -f odd_pipe.f -o sim_odd_pipe
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_odd_pipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" sim.log; then
    exit 0
fi
exit 1

// File: testbench/odd_pipe_assert.sv
`timescale 1ns/1ps
`default_nettype none

module odd_pipe_assert
    import odd_pipe_pkg::*;
#(
    parameter int FWD_DEPTH = 7
)
(
    input  logic                       clock,
    input  logic                       reset,
    input  fwd_entry_t [0:FWD_DEPTH-1] fwd_stages,
    input  logic                       branch_taken,
    input  logic                       flush
);

    int failures = 0;

    // a flush comes only from a taken branch sitting at stage one
    assert property (@(posedge clock) disable iff (reset)
        (flush == branch_taken) && (!flush || fwd_stages[0].unit_id == UNIT_BRANCH))
        else
        begin
            failures++;
            $error("flush without a taken branch at stage one");
        end

    // the squashed slot shows up as an empty stage one entry
    assert property (@(posedge clock) disable iff (reset)
        $past(flush) |-> fwd_stages[0] == '0)
        else
        begin
            failures++;
            $error("stage one not empty after a flush");
        end

    for (genvar k = 1; k < FWD_DEPTH; k++)
    begin : g_shift
        assert property (@(posedge clock) disable iff (reset)
            !$past(reset) |-> fwd_stages[k] == $past(fwd_stages[k-1]))
            else
            begin
                failures++;
                $error("stage %0d did not take the previous stage", k + 1);
            end
    end

endmodule

`default_nettype wire

// File: testbench/odd_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module odd_pipe_tb
    import odd_pipe_pkg::*;
();

    localparam int FWD_DEPTH    = 7;
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_CYCLES   = 400;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + FWD_DEPTH + 10) * PERIOD;

    logic                       clock;
    logic                       reset;
    odd_instr_t                 instr;
    fwd_entry_t [0:FWD_DEPTH-1] fwd_stages;
    logic                       branch_taken;
    logic                       flush;
    pc_t                        target_pc;

    int         seed;
    int         errors;
    int         checks;
    odd_instr_t model_issue;
    fwd_entry_t hist [1:FWD_DEPTH-1];
    logic       rst_seen;
    logic       after_flush;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    odd_pipe #(.FWD_DEPTH(FWD_DEPTH)) u_dut (
        .clock        (clock),
        .reset        (reset),
        .instr        (instr),
        .fwd_stages   (fwd_stages),
        .branch_taken (branch_taken),
        .flush        (flush),
        .target_pc    (target_pc)
    );

    bind odd_pipe odd_pipe_assert #(.FWD_DEPTH(FWD_DEPTH)) u_assert (
        .clock        (clock),
        .reset        (reset),
        .fwd_stages   (fwd_stages),
        .branch_taken (branch_taken),
        .flush        (flush)
    );

    // bit i of the result takes ra bit i+n with wrap or zero fill
    function automatic quadword_t expect_permute(odd_instr_t in);
        logic [31:0] rbw;
        logic [31:0] imm;
        int          n;
        logic        wrap;
        quadword_t   res;
        rbw  = in.rb[0:31];
        imm  = {25'd0, in.i7};
        wrap = 1'b0;
        n    = 0;
        case (in.opcode)
            SHLQBI:  n = int'(rbw % 8);
            SHLQBII: n = int'(imm % 8);
            SHLQBY:  n = int'(rbw % 32) * 8;
            SHLQBYI: n = int'(imm % 32) * 8;
            ROTQBI:
            begin
                wrap = 1'b1;
                n    = int'(rbw % 8);
            end
            ROTQBII:
            begin
                wrap = 1'b1;
                n    = int'(imm % 8);
            end
            ROTQBY:
            begin
                wrap = 1'b1;
                n    = int'(rbw % 16) * 8;
            end
            ROTQBYI:
            begin
                wrap = 1'b1;
                n    = int'(imm % 16) * 8;
            end
            default: n = 0;
        endcase
        for (int i = 0; i < QUAD_BITS; i++)
        begin
            if (i + n < QUAD_BITS)
                res[i] = in.ra[i + n];
            else
                res[i] = wrap ? in.ra[i + n - QUAD_BITS] : 1'b0;
        end
        return res;
    endfunction

    function automatic logic expect_taken(odd_instr_t in);
        logic [31:0] rbw;
        rbw = in.rb[0:31];
        case (in.opcode)
            BR, BRA, BRSL: return 1'b1;
            BRZ:           return rbw == 32'd0;
            BRNZ:          return rbw != 32'd0;
            default:       return 1'b0;
        endcase
    endfunction

    function automatic pc_t expect_target(odd_instr_t in);
        logic signed [15:0] imm16;
        int                 off;
        imm16 = in.i16;
        off   = imm16 * 4;
        if (!expect_taken(in))
            return '0;
        if (in.opcode == BRA)
            return pc_t'(off);
        return in.pc + pc_t'(off);
    endfunction

    function automatic fwd_entry_t expect_entry(odd_instr_t in);
        fwd_entry_t e;
        e = '0;
        case (in.opcode)
            SHLQBI, SHLQBII, SHLQBY, SHLQBYI, ROTQBI, ROTQBII, ROTQBY, ROTQBYI:
            begin
                e = '{UNIT_PERMUTE, expect_permute(in), 1'b1, in.rt_address, LAT_PERMUTE};
            end
            BR, BRA, BRZ, BRNZ:
                e = '{UNIT_BRANCH, '0, 1'b0, in.rt_address, LAT_BRANCH};
            BRSL:
            begin
                e = '{UNIT_BRANCH, '0, 1'b1, in.rt_address, LAT_BRANCH};
                e.rt_value[0:31] = in.pc + 32'd4;
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    task automatic draw_instr(output odd_instr_t in);
        int op_sel;
        op_sel       = $unsigned($random(seed)) % 14;
        in.opcode    = odd_opcode_t'(op_sel[3:0]);
        in.ra        = {$random(seed), $random(seed), $random(seed), $random(seed)};
        in.rb        = {$random(seed), $random(seed), $random(seed), $random(seed)};
        in.rt_address = reg_addr_t'($random(seed));
        in.i7        = 7'($random(seed));
        in.i16       = 16'($random(seed));
        in.pc        = $random(seed);
        // zero rb words often enough to see BRZ taken
        if (($random(seed) & 3) == 0)
            in.rb[0:31] = '0;
    endtask

    task automatic check_value(string name, logic [142:0] got, logic [142:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    task automatic run_checks();
        check_value("branch_taken", 143'(branch_taken), 143'(expect_taken(model_issue)));
        check_value("flush", 143'(flush), 143'(expect_taken(model_issue)));
        check_value("target_pc", 143'(target_pc), 143'(expect_target(model_issue)));
        check_value("fwd_stages[0]", fwd_stages[0], expect_entry(model_issue));
        for (int k = 1; k < FWD_DEPTH; k++)
            check_value($sformatf("fwd_stages[%0d]", k), fwd_stages[k], hist[k]);
        if (after_flush)
        begin
            assert (fwd_stages[0] === '0)
            else
            begin
                errors++;
                $display("an instruction behind a taken branch reached stage one");
            end
        end
        if (rst_seen)
        begin
            assert (!branch_taken && !flush && target_pc === '0 && fwd_stages === '0)
            else
            begin
                errors++;
                $display("outputs were not cleared by reset");
            end
        end
        after_flush = expect_taken(model_issue);
    endtask

    // reference pipe updated on the same edge as the DUT registers
    always @(posedge clock)
    begin
        rst_seen = reset;
        if (reset)
        begin
            model_issue = '0;
            for (int k = 1; k < FWD_DEPTH; k++)
                hist[k] = '0;
        end
        else
        begin
            for (int k = FWD_DEPTH - 1; k > 1; k--)
                hist[k] = hist[k-1];
            hist[1] = expect_entry(model_issue);
            model_issue = expect_taken(model_issue) ? '0 : instr;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the test did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        seed        = 32'h79f6b50a;
        errors      = 0;
        checks      = 0;
        instr       = '0;
        model_issue = '0;
        after_flush = 1'b0;
        rst_seen    = 1'b1;
        @(posedge clock);
        for (int cycle = 0; cycle < RESET_CYCLES + NUM_CYCLES + FWD_DEPTH; cycle++)
        begin
            @(negedge clock);
            run_checks();
            // random work then NOPs to drain the stages
            if (cycle < RESET_CYCLES + NUM_CYCLES)
                draw_instr(instr);
            else
                instr = '0;
        end
        errors = errors + u_dut.u_assert.failures;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
)
(
    output logic clock,
    output logic reset
);

    initial
    begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // reset drops on a falling edge, away from the sampling edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire
